// ==== Bender.yml ====
package:
  name: mem_subsystem

sources:
  - files:
      - common/mem_stage_pkg.sv
      - source/ex_mem_capture.sv
      - source/mem_access_fsm.sv
      - source/mem_wb_register.sv
      - data_ram/data_ram.sv
      - source/mem_subsystem.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_mem_subsystem.sv

// ==== common/mem_stage_pkg.sv ====
package mem_stage_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [3:0]  mem_op_t;
    typedef logic [3:0]  wb_sel_t;

    localparam mem_op_t MEM_X       = 4'd0;
    localparam mem_op_t MEM_LB      = 4'd1;
    localparam mem_op_t MEM_LBU     = 4'd2;
    localparam mem_op_t MEM_LH      = 4'd3;
    localparam mem_op_t MEM_LHU     = 4'd4;
    localparam mem_op_t MEM_LW      = 4'd5;
    localparam mem_op_t MEM_SB      = 4'd6;
    localparam mem_op_t MEM_SH      = 4'd7;
    localparam mem_op_t MEM_SW      = 4'd8;
    localparam mem_op_t MEM_AMOSWAP = 4'd9;   // Read old word, then write rs2

    localparam word_t   INST_NOP = 32'h0000_0013;   // addi x0, x0, 0
    localparam word_t   PC_NOP   = 32'hffff_ffff;
    localparam wb_sel_t WB_X     = 4'd0;

    localparam int RAM_WORDS    = 1024;
    localparam int RAM_IDX_W    = $clog2(RAM_WORDS);
    localparam int READ_LATENCY = 2;
    localparam int LAT_CNT_W    = $clog2(READ_LATENCY + 1);

    typedef struct packed {
        word_t     pc;
        word_t     inst;
        word_t     alu_out;
        word_t     rs2_data;
        logic      br_flg;
        word_t     br_target;
        mem_op_t   mem_op;
        logic      rf_wen;
        wb_sel_t   wb_sel;
        reg_addr_t wb_addr;
        logic      jmp_flg;
    } ex_mem_t;

    typedef struct packed {
        word_t     pc;
        word_t     inst;
        word_t     alu_out;
        word_t     read_data;
        logic      br_flg;
        word_t     br_target;
        logic      rf_wen;
        wb_sel_t   wb_sel;
        reg_addr_t wb_addr;
        logic      jmp_flg;
    } mem_wb_t;

    typedef struct packed {
        logic       start;
        logic       write;
        word_t      addr;
        word_t      wdata;   // Low-aligned, RAM moves it to the lane
        logic [3:0] wmask;
    } mem_cmd_t;

    localparam ex_mem_t EX_MEM_NOP = '{
        pc: PC_NOP, inst: INST_NOP, alu_out: '0, rs2_data: '0, br_flg: 1'b0,
        br_target: '0, mem_op: MEM_X, rf_wen: 1'b0, wb_sel: WB_X, wb_addr: '0,
        jmp_flg: 1'b0
    };

    localparam mem_wb_t MEM_WB_NOP = '{
        pc: PC_NOP, inst: INST_NOP, alu_out: '0, read_data: '0, br_flg: 1'b0,
        br_target: '0, rf_wen: 1'b0, wb_sel: WB_X, wb_addr: '0, jmp_flg: 1'b0
    };

endpackage

// ==== data_ram/data_ram.sv ====
`timescale 1ns/1ps

module data_ram (
    input  logic                    clk,
    input  logic                    rst_n,
    input  mem_stage_pkg::mem_cmd_t cmd,
    output logic                    ready,
    output mem_stage_pkg::word_t    rdata,
    output logic                    rdata_valid
);

    import mem_stage_pkg::*;

    word_t                mem [RAM_WORDS];
    logic [RAM_IDX_W-1:0] idx;
    logic [1:0]           lane;
    word_t                wdata_sh;
    logic [3:0]           wmask_sh;
    logic                 accept;
    logic [LAT_CNT_W-1:0] busy_cnt;
    logic                 rd_pend;

    assign idx      = cmd.addr[RAM_IDX_W+1:2];
    assign lane     = cmd.addr[1:0];
    assign wdata_sh = cmd.wdata << {lane, 3'b000};
    assign wmask_sh = cmd.wmask << lane;   // Lanes past bit 3 fall off
    assign accept   = cmd.start && ready;

    assign ready       = (busy_cnt == '0);
    assign rdata_valid = rd_pend && (busy_cnt == LAT_CNT_W'(1));

    always_ff @(posedge clk) begin
        if (accept && cmd.write) begin
            for (int b = 0; b < 4; b++) begin
                if (wmask_sh[b]) begin
                    mem[idx][8*b +: 8] <= wdata_sh[8*b +: 8];
                end
            end
        end
        if (accept && !cmd.write) begin
            rdata <= mem[idx] >> {lane, 3'b000};   // Returned at bit 0
        end
    end

    // Countdown to ready, a read's valid falls on its last busy cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_cnt <= '0;
            rd_pend  <= 1'b0;
        end else if (accept) begin
            busy_cnt <= cmd.write ? LAT_CNT_W'(1) : LAT_CNT_W'(READ_LATENCY);
            rd_pend  <= !cmd.write;
        end else if (busy_cnt != '0) begin
            busy_cnt <= busy_cnt - 1'b1;
            if (busy_cnt == LAT_CNT_W'(1)) begin
                rd_pend <= 1'b0;
            end
        end
    end

endmodule

// ==== list.f ====
+incdir+sim
common/mem_stage_pkg.sv
source/ex_mem_capture.sv
source/mem_access_fsm.sv
source/mem_wb_register.sv
data_ram/data_ram.sv
source/mem_subsystem.sv
sim/tb_mem_subsystem.sv

// ==== sim/tb_mem_tasks.svh ====
// Fibonacci LFSR, taps 32 22 2 1
function automatic word_t take_bits(input int n);
    word_t r;
    logic  fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        r    = {r[30:0], fb};
    end
    return r;
endfunction

function automatic word_t random_word_addr();
    return {20'b0, 10'(take_bits(10)), 2'b00};
endfunction

function automatic ex_mem_t make_bundle(input mem_op_t op, input word_t addr, input word_t data);
    ex_mem_t b;
    b.pc        = next_pc;
    b.inst      = take_bits(32);
    b.alu_out   = addr;
    b.rs2_data  = data;
    b.br_flg    = 1'(take_bits(1));
    b.br_target = take_bits(32);
    b.mem_op    = op;
    b.rf_wen    = 1'(take_bits(1));
    b.wb_sel    = 4'(take_bits(4));
    b.wb_addr   = 5'(take_bits(5));
    b.jmp_flg   = 1'(take_bits(1));
    next_pc     = next_pc + 4;
    return b;
endfunction

// LB and LH sign-extend, LBU and LHU zero-extend, a swap returns the old word
function automatic word_t expect_load(input mem_op_t op, input word_t addr);
    word_t w;
    w = {ref_mem[addr+3], ref_mem[addr+2], ref_mem[addr+1], ref_mem[addr]};
    case (op)
        MEM_LB:  return {{24{w[7]}}, w[7:0]};
        MEM_LBU: return {24'b0, w[7:0]};
        MEM_LH:  return {{16{w[15]}}, w[15:0]};
        MEM_LHU: return {16'b0, w[15:0]};
        default: return w;
    endcase
endfunction

task automatic write_reference(input mem_op_t op, input word_t addr, input word_t data);
    int n;
    n = (op == MEM_SB) ? 1 : (op == MEM_SH) ? 2 : 4;
    for (int i = 0; i < n; i++) begin
        ref_mem[addr+i] = data[8*i +: 8];
    end
endtask

// Present one bundle and hold it while the stage stalls
task automatic send_bundle(input ex_mem_t b, input logic flush_it);
    @(posedge clk);
    ex_mem       <= b;
    flush        <= flush_it;
    stall_cycles = 0;
    @(negedge clk);
    while (stall) begin
        compare_value("fwd_rf_wen", fwd_rf_wen, b.rf_wen);
        compare_value("fwd_wb_addr", fwd_wb_addr, b.wb_addr);
        stall_cycles++;
        @(negedge clk);
    end
endtask

task automatic issue_bundle(input ex_mem_t b);
    mem_op_t op;
    op = b.mem_op;
    exp_bundle.push_back(b);
    exp_data.push_back(expect_load(op, b.alu_out));
    exp_has_data.push_back(op != MEM_X && op != MEM_SB && op != MEM_SH && op != MEM_SW);
    if (op == MEM_SB || op == MEM_SH || op == MEM_SW || op == MEM_AMOSWAP) begin
        write_reference(op, b.alu_out, b.rs2_data);
    end
    send_bundle(b, 1'b0);
endtask

task automatic issue(input mem_op_t op, input word_t addr, input word_t data);
    issue_bundle(make_bundle(op, addr, data));
endtask

// Let the last bundle leave, then match everything that came out in order
task automatic drain_and_compare();
    ex_mem_t b;
    mem_wb_t got;
    word_t   d;
    logic    has_data;
    @(posedge clk);
    ex_mem <= EX_MEM_NOP;
    flush  <= 1'b0;
    @(posedge clk);
    while (exp_bundle.size() > 0) begin
        b        = exp_bundle.pop_front();
        d        = exp_data.pop_front();
        has_data = exp_has_data.pop_front();
        assert (wb_seen.size() > 0) else begin
            abort_run($sformatf("Bundle with pc %h never reached mem_wb", b.pc));
        end
        got = wb_seen.pop_front();
        compare_value("mem_wb.pc", got.pc, b.pc);
        compare_value("mem_wb.inst", got.inst, b.inst);
        compare_value("mem_wb.alu_out", got.alu_out, b.alu_out);
        compare_value("mem_wb.br_target", got.br_target, b.br_target);
        compare_value("mem_wb.flags",
                      {got.br_flg, got.rf_wen, got.jmp_flg, got.wb_sel, got.wb_addr},
                      {b.br_flg, b.rf_wen, b.jmp_flg, b.wb_sel, b.wb_addr});
        if (has_data) begin
            compare_value("mem_wb.read_data", got.read_data, d);
        end
    end
    assert (wb_seen.size() == 0) else begin
        abort_run("mem_wb showed a bundle that was flushed or had already left");
    end
endtask

task automatic check_bubble();
    compare_value("mem_wb.rf_wen", mem_wb.rf_wen, 1'b0);
    compare_value("mem_wb.inst", mem_wb.inst, INST_NOP);
    compare_value("mem_wb.pc", mem_wb.pc, PC_NOP);
endtask

task automatic reset_and_passthrough();
    @(negedge clk);
    check_bubble();
    compare_value("stall", stall, 1'b0);
    issue(MEM_X, take_bits(32), take_bits(32));
    compare_value("stall cycles", stall_cycles, 0);
    drain_and_compare();
endtask

task automatic store_load_widths();
    word_t base;
    for (int k = 0; k < 3; k++) begin
        base = random_word_addr();
        issue(MEM_SW, base, take_bits(32));
        issue(MEM_SH, base + 2 * take_bits(1), take_bits(32));
        issue(MEM_SB, base + take_bits(2), take_bits(32));
        issue(MEM_LW, base, '0);
        issue(MEM_LH, base + 2 * take_bits(1), '0);
        issue(MEM_LHU, base + 2 * take_bits(1), '0);
        issue(MEM_LB, base + take_bits(2), '0);
        issue(MEM_LBU, base + take_bits(2), '0);
    end
    drain_and_compare();
endtask

task automatic back_pressure();
    word_t a;
    a = random_word_addr();
    issue(MEM_SW, a, take_bits(32));
    compare_value("stall cycles", stall_cycles, 0);
    issue(MEM_SW, a ^ 32'h0000_0800, take_bits(32));   // RAM busy after first write
    compare_value("stall cycles", stall_cycles, 1);
    issue(MEM_LW, a, '0);
    compare_value("stall cycles", stall_cycles, READ_LATENCY + 1);
    drain_and_compare();
endtask

task automatic atomic_swap();
    word_t a;
    a = random_word_addr();
    issue(MEM_SW, a, take_bits(32));
    issue(MEM_AMOSWAP, a, take_bits(32));
    issue(MEM_LW, a, '0);
    drain_and_compare();
endtask

task automatic flush_squash();
    word_t   a;
    ex_mem_t b;
    a = random_word_addr();
    issue(MEM_SW, a, take_bits(32));
    issue(MEM_SW, a ^ 32'h0000_0800, take_bits(32));
    drain_and_compare();   // RAM ready, an unsquashed store would retire at once
    send_bundle(make_bundle(MEM_SW, a, take_bits(32)), 1'b1);
    @(posedge clk);
    ex_mem <= EX_MEM_NOP;
    flush  <= 1'b0;
    @(negedge clk);
    check_bubble();
    issue(MEM_LW, a, '0);   // Still the first store's word
    b = make_bundle(MEM_LW, a, '0);
    @(posedge clk);
    ex_mem <= b;
    @(negedge clk);
    compare_value("stall", stall, 1'b1);
    @(posedge clk);
    flush <= 1'b1;
    @(negedge clk);
    compare_value("stall", stall, 1'b0);
    issue(MEM_LW, a ^ 32'h0000_0800, '0);   // Must not pick up the abandoned read
    drain_and_compare();
endtask

task automatic forwarding_during_stall();
    word_t   a;
    ex_mem_t b;
    a = random_word_addr();
    issue(MEM_SW, a, take_bits(32));
    drain_and_compare();
    b         = make_bundle(MEM_LW, a, '0);
    b.rf_wen  = 1'b1;
    b.wb_addr = 5'(take_bits(5)) | 5'd1;
    issue_bundle(b);
    compare_value("stall cycles", stall_cycles, READ_LATENCY);
    drain_and_compare();
endtask

// ==== sim/tb_mem_subsystem.sv ====
`timescale 1ns/1ps

module tb_mem_subsystem;

    import mem_stage_pkg::*;

    localparam int CLK_PERIOD  = 4;
    localparam int TEST_CYCLES = 20 + 120 + 20 + 20 + 30 + 20;   // Rough length of each test

    logic      clk;
    logic      rst_n;
    ex_mem_t   ex_mem;
    logic      flush;
    mem_wb_t   mem_wb;
    logic      stall;
    logic      fwd_rf_wen;
    reg_addr_t fwd_wb_addr;

    logic [7:0]  ref_mem [RAM_WORDS*4];   // Byte model of the RAM, little endian
    logic [31:0] lfsr = 32'h284974d6;
    word_t       next_pc = 32'h0000_1000;
    mem_wb_t     wb_seen [$];   // Bundles that left the stage, bubbles dropped
    ex_mem_t     exp_bundle [$];
    word_t       exp_data [$];
    logic        exp_has_data [$];
    int          stall_cycles;

    mem_subsystem DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .ex_mem      (ex_mem),
        .flush       (flush),
        .mem_wb      (mem_wb),
        .stall       (stall),
        .fwd_rf_wen  (fwd_rf_wen),
        .fwd_wb_addr (fwd_wb_addr)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(negedge clk) begin
        if (rst_n && mem_wb.pc !== PC_NOP) begin
            wb_seen.push_back(mem_wb);
        end
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("SOME TESTS FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic compare_value(input string name, input word_t got, input word_t exp);
        assert (got === exp) else begin
            abort_run($sformatf("Fail at %0t ns: %s is %h, expected %h",
                                $time, name, got, exp));
        end
    endtask

    `include "tb_mem_tasks.svh"

    initial begin
        #(TEST_CYCLES * 10 * CLK_PERIOD);
        abort_run("Timeout: the test sequence did not finish in time");
    end

    initial begin
        clk    = 1'b0;
        rst_n  = 1'b0;
        flush  = 1'b0;
        ex_mem = EX_MEM_NOP;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        reset_and_passthrough();
        store_load_widths();
        back_pressure();
        atomic_swap();
        flush_squash();
        forwarding_during_stall();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// ==== source/ex_mem_capture.sv ====
`timescale 1ns/1ps

module ex_mem_capture (
    input  logic                     clk,
    input  logic                     rst_n,
    input  mem_stage_pkg::ex_mem_t   ex_mem,
    input  logic                     flush,
    input  logic                     hold,
    input  logic                     swap_to_store,
    output mem_stage_pkg::ex_mem_t   cur,
    output mem_stage_pkg::mem_op_t   in_flight_op,
    output logic                     fwd_rf_wen,
    output mem_stage_pkg::reg_addr_t fwd_wb_addr
);

    import mem_stage_pkg::*;

    ex_mem_t squashed;
    ex_mem_t saved;
    mem_op_t saved_op;

    // A writeback flush turns the incoming bundle into a bubble
    assign squashed = flush ? EX_MEM_NOP : ex_mem;

    always_ff @(posedge clk) begin
        if (!hold) begin
            saved <= squashed;
        end
    end

    // Op kept apart so that a swap can turn into its store half
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            saved_op <= MEM_X;
        end else if (!hold) begin
            saved_op <= squashed.mem_op;
        end else if (swap_to_store) begin
            saved_op <= MEM_SW;
        end
    end

    always_comb begin
        cur = squashed;
        if (hold) begin
            cur        = saved;
            cur.mem_op = saved_op;
        end
    end

    assign in_flight_op = saved_op;

    // Hazard unit sees whatever currently occupies the stage
    assign fwd_rf_wen  = cur.rf_wen;
    assign fwd_wb_addr = cur.wb_addr;

endmodule

// ==== source/mem_access_fsm.sv ====
`timescale 1ns/1ps

module mem_access_fsm (
    input  logic                     clk,
    input  logic                     rst_n,
    input  mem_stage_pkg::ex_mem_t   cur,
    input  mem_stage_pkg::mem_op_t   in_flight_op,
    input  logic                     flush,
    input  logic                     ready,
    input  mem_stage_pkg::word_t     rdata,
    input  logic                     rdata_valid,
    output mem_stage_pkg::mem_cmd_t  cmd,
    output logic                     hold,
    output logic                     swap_to_store,
    output logic                     stall,
    output logic                     emit_cur,
    output logic                     emit_saved,
    output mem_stage_pkg::word_t     swap_data
);

    import mem_stage_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        WAIT_READY,
        WAIT_RDATA
    } acc_state_t;

    acc_state_t state;
    acc_state_t state_next;
    acc_state_t eff_state;
    mem_op_t    op;
    logic       is_load;
    logic       is_store;
    logic       is_swap;

    // Flush abandons the access, a late rdata_valid then finds us idle
    assign eff_state = flush ? IDLE : state;
    assign op        = (eff_state == IDLE) ? cur.mem_op : in_flight_op;
    assign hold      = (eff_state != IDLE);

    always_comb begin
        is_load  = 1'b0;
        is_store = 1'b0;
        is_swap  = 1'b0;
        case (op)
            MEM_LB, MEM_LBU, MEM_LH, MEM_LHU, MEM_LW: is_load = 1'b1;
            MEM_SB, MEM_SH, MEM_SW:                   is_store = 1'b1;
            MEM_AMOSWAP:                              is_swap = 1'b1;
            default: ;
        endcase
    end

    always_comb begin
        cmd.start = (eff_state == WAIT_READY) ||
                    ((eff_state == IDLE) && (is_load || is_store || is_swap));
        cmd.write = cmd.start && is_store;
        cmd.addr  = cur.alu_out;
        cmd.wdata = cur.rs2_data;
        case (op)
            MEM_SB:  cmd.wmask = 4'b0001;
            MEM_SH:  cmd.wmask = 4'b0011;
            default: cmd.wmask = 4'b1111;
        endcase
    end

    always_comb begin
        state_next    = eff_state;
        emit_cur      = 1'b0;
        emit_saved    = 1'b0;
        swap_to_store = 1'b0;
        case (eff_state)
            IDLE: begin
                if (!(is_load || is_store || is_swap)) begin
                    emit_cur = 1'b1;
                end else if (!ready) begin
                    state_next = WAIT_READY;
                end else if (is_store) begin
                    emit_cur = 1'b1;   // Store retires on acceptance
                end else begin
                    state_next = WAIT_RDATA;
                end
            end
            WAIT_READY: begin
                if (ready) begin
                    if (is_store) begin
                        emit_saved = 1'b1;
                        state_next = IDLE;
                    end else begin
                        state_next = WAIT_RDATA;
                    end
                end
            end
            WAIT_RDATA: begin
                if (rdata_valid) begin
                    if (is_swap) begin
                        swap_to_store = 1'b1;   // Second half writes rs2
                        state_next    = WAIT_READY;
                    end else begin
                        emit_saved = 1'b1;
                        state_next = IDLE;
                    end
                end
            end
            default: state_next = IDLE;
        endcase
    end

    assign stall = !(emit_cur || emit_saved);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (swap_to_store) begin
            swap_data <= rdata;   // Old word goes back to the register file
        end
    end

endmodule

// ==== source/mem_subsystem.sv ====
`timescale 1ns/1ps

module mem_subsystem (
    input  logic                     clk,
    input  logic                     rst_n,
    input  mem_stage_pkg::ex_mem_t   ex_mem,
    input  logic                     flush,
    output mem_stage_pkg::mem_wb_t   mem_wb,
    output logic                     stall,
    output logic                     fwd_rf_wen,
    output mem_stage_pkg::reg_addr_t fwd_wb_addr
);

    import mem_stage_pkg::*;

    ex_mem_t  cur;
    mem_op_t  in_flight_op;
    logic     hold;
    logic     swap_to_store;
    logic     emit_cur;
    logic     emit_saved;
    word_t    swap_data;
    mem_cmd_t cmd;
    logic     ready;
    word_t    rdata;
    logic     rdata_valid;

    ex_mem_capture u_capture (
        .clk           (clk),
        .rst_n         (rst_n),
        .ex_mem        (ex_mem),
        .flush         (flush),
        .hold          (hold),
        .swap_to_store (swap_to_store),
        .cur           (cur),
        .in_flight_op  (in_flight_op),
        .fwd_rf_wen    (fwd_rf_wen),
        .fwd_wb_addr   (fwd_wb_addr)
    );

    mem_access_fsm u_fsm (
        .clk           (clk),
        .rst_n         (rst_n),
        .cur           (cur),
        .in_flight_op  (in_flight_op),
        .flush         (flush),
        .ready         (ready),
        .rdata         (rdata),
        .rdata_valid   (rdata_valid),
        .cmd           (cmd),
        .hold          (hold),
        .swap_to_store (swap_to_store),
        .stall         (stall),
        .emit_cur      (emit_cur),
        .emit_saved    (emit_saved),
        .swap_data     (swap_data)
    );

    mem_wb_register u_wb_reg (
        .clk        (clk),
        .rst_n      (rst_n),
        .cur        (cur),
        .load_op    (in_flight_op),
        .emit_cur   (emit_cur),
        .emit_saved (emit_saved),
        .rdata      (rdata),
        .swap_data  (swap_data),
        .mem_wb     (mem_wb)
    );

    data_ram u_ram (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd         (cmd),
        .ready       (ready),
        .rdata       (rdata),
        .rdata_valid (rdata_valid)
    );

endmodule

// ==== source/mem_wb_register.sv ====
`timescale 1ns/1ps

module mem_wb_register (
    input  logic                   clk,
    input  logic                   rst_n,
    input  mem_stage_pkg::ex_mem_t cur,
    input  mem_stage_pkg::mem_op_t load_op,
    input  logic                   emit_cur,
    input  logic                   emit_saved,
    input  mem_stage_pkg::word_t   rdata,
    input  mem_stage_pkg::word_t   swap_data,
    output mem_stage_pkg::mem_wb_t mem_wb
);

    import mem_stage_pkg::*;

    word_t   read_ext;
    mem_wb_t wb_next;

    always_comb begin
        case (load_op)
            MEM_LB:  read_ext = {{24{rdata[7]}}, rdata[7:0]};
            MEM_LBU: read_ext = {24'b0, rdata[7:0]};
            MEM_LH:  read_ext = {{16{rdata[15]}}, rdata[15:0]};
            MEM_LHU: read_ext = {16'b0, rdata[15:0]};
            // A swap finishes as its SW half, stores ignore read_data
            MEM_SW, MEM_AMOSWAP: read_ext = swap_data;
            default: read_ext = rdata;
        endcase
    end

    always_comb begin
        wb_next.pc        = cur.pc;
        wb_next.inst      = cur.inst;
        wb_next.alu_out   = cur.alu_out;
        wb_next.read_data = read_ext;
        wb_next.br_flg    = cur.br_flg;
        wb_next.br_target = cur.br_target;
        wb_next.rf_wen    = cur.rf_wen;
        wb_next.wb_sel    = cur.wb_sel;
        wb_next.wb_addr   = cur.wb_addr;
        wb_next.jmp_flg   = cur.jmp_flg;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_wb <= MEM_WB_NOP;
        end else if (emit_cur || emit_saved) begin
            mem_wb <= wb_next;
        end else begin
            mem_wb <= MEM_WB_NOP;   // Bubble while stalled
        end
    end

endmodule
